// File: Bender.yml
package:
  name: core

export_include_dirs:
  - source

sources:
  - files:
      - source/core_pkg.sv
      - source/fetch_stage.sv
      - source/decode_stage.sv
      - source/execute_stage.sv
      - source/register_file.sv
      - source/core_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/core_tb.sv

// File: compile.f
+incdir+source
source/core_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/register_file.sv
source/core_top.sv
testbench/core_tb.sv

// File: source/core_params.svh
// core parameters: widths, register count, reset address and the RV64I encodings in use
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath and instruction widths
`define CORE_XLEN            64
`define CORE_INST_WIDTH      32

// general register file
`define CORE_REG_COUNT       32
`define CORE_REG_ADDR_WIDTH  5

// first fetch address after reset
`define CORE_RESET_PC        64'h0000_0000_8000_0000

// major opcodes
`define CORE_OPC_OP_IMM      7'b0010011
`define CORE_OPC_OP          7'b0110011
`define CORE_OPC_LUI         7'b0110111

// funct3 values, shared by OP and OP-IMM
`define CORE_F3_ADD          3'b000
`define CORE_F3_SLL          3'b001
`define CORE_F3_SLT          3'b010
`define CORE_F3_SLTU         3'b011
`define CORE_F3_XOR          3'b100
`define CORE_F3_SRL          3'b101
`define CORE_F3_OR           3'b110
`define CORE_F3_AND          3'b111

// funct7 for SUB, also the SRA/SRAI marker
`define CORE_F7_SUB          7'b0100000

`endif

// File: source/core_pkg.sv
// core package: shared vector types and the ALU operation encoding
`default_nettype none

`include "core_params.svh"

package core_pkg;

  // one data word
  typedef logic [`CORE_XLEN-1:0] xlen_t;

  // one instruction word
  typedef logic [`CORE_INST_WIDTH-1:0] inst_t;

  // register index
  typedef logic [`CORE_REG_ADDR_WIDTH-1:0] reg_addr_t;

  // ALU operations
  // PASS_B forwards the second operand, used for LUI
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

endpackage

`default_nettype wire

// File: source/core_top.sv
// core top: in-order RV64 integer core, fetch, decode, execute and register file
`timescale 1ns/1ps
`default_nettype none

module core_top (
  input  logic                clock,
  input  logic                reset,
  // fetch port
  output logic                fetch_valid,
  output core_pkg::xlen_t     fetch_addr,
  input  logic                fetch_ready,
  input  core_pkg::inst_t     fetch_inst,
  // commit port
  output logic                commit_valid,
  output core_pkg::xlen_t     commit_pc,
  output core_pkg::inst_t     commit_inst,
  output core_pkg::reg_addr_t commit_rd,
  output logic                commit_wen,
  output core_pkg::xlen_t     commit_data
);

  // fetch to decode
  logic                fd_valid;
  core_pkg::xlen_t     fd_pc;
  core_pkg::inst_t     fd_inst;

  // decode to execute
  logic                de_valid;
  core_pkg::xlen_t     de_pc;
  core_pkg::inst_t     de_inst;
  core_pkg::reg_addr_t de_rs1;
  core_pkg::reg_addr_t de_rs2;
  core_pkg::reg_addr_t de_rd;
  logic                de_wen;
  logic                de_use_imm;
  core_pkg::xlen_t     de_imm;
  core_pkg::alu_op_e   de_alu_op;

  // execute to register file
  core_pkg::reg_addr_t rs1_addr;
  core_pkg::reg_addr_t rs2_addr;
  core_pkg::xlen_t     rs1_data;
  core_pkg::xlen_t     rs2_data;

  fetch_stage u_fetch (
    .clock       (clock),
    .reset       (reset),
    .fetch_ready (fetch_ready),
    .fetch_inst  (fetch_inst),
    .fetch_valid (fetch_valid),
    .fetch_addr  (fetch_addr),
    .fd_valid    (fd_valid),
    .fd_pc       (fd_pc),
    .fd_inst     (fd_inst)
  );

  decode_stage u_decode (
    .clock      (clock),
    .reset      (reset),
    .fd_valid   (fd_valid),
    .fd_pc      (fd_pc),
    .fd_inst    (fd_inst),
    .de_valid   (de_valid),
    .de_pc      (de_pc),
    .de_inst    (de_inst),
    .de_rs1     (de_rs1),
    .de_rs2     (de_rs2),
    .de_rd      (de_rd),
    .de_wen     (de_wen),
    .de_use_imm (de_use_imm),
    .de_imm     (de_imm),
    .de_alu_op  (de_alu_op)
  );

  execute_stage u_execute (
    .clock        (clock),
    .reset        (reset),
    .de_valid     (de_valid),
    .de_pc        (de_pc),
    .de_inst      (de_inst),
    .de_rs1       (de_rs1),
    .de_rs2       (de_rs2),
    .de_rd        (de_rd),
    .de_wen       (de_wen),
    .de_use_imm   (de_use_imm),
    .de_imm       (de_imm),
    .de_alu_op    (de_alu_op),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_inst  (commit_inst),
    .commit_rd    (commit_rd),
    .commit_wen   (commit_wen),
    .commit_data  (commit_data)
  );

  // written from the writeback register one edge after commit
  register_file u_regfile (
    .clock        (clock),
    .reset        (reset),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .write_enable (commit_wen),
    .write_addr   (commit_rd),
    .write_data   (commit_data)
  );

endmodule

`default_nettype wire

// File: source/decode_stage.sv
// decode stage: field split, immediates, ALU op mapping and the decode-to-execute register
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module decode_stage (
  input  logic                clock,
  input  logic                reset,
  // from fetch
  input  logic                fd_valid,
  input  core_pkg::xlen_t     fd_pc,
  input  core_pkg::inst_t     fd_inst,
  // to execute
  output logic                de_valid,
  output core_pkg::xlen_t     de_pc,
  output core_pkg::inst_t     de_inst,
  output core_pkg::reg_addr_t de_rs1,
  output core_pkg::reg_addr_t de_rs2,
  output core_pkg::reg_addr_t de_rd,
  output logic                de_wen,
  output logic                de_use_imm,
  output core_pkg::xlen_t     de_imm,
  output core_pkg::alu_op_e   de_alu_op
);

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  core_pkg::reg_addr_t rd;
  core_pkg::xlen_t     imm_i;
  core_pkg::xlen_t     imm_u;
  logic                supported;
  logic                use_imm;
  core_pkg::alu_op_e   alu_op;

  assign opcode = fd_inst[6:0];
  assign rd     = fd_inst[11:7];
  assign funct3 = fd_inst[14:12];
  assign funct7 = fd_inst[31:25];

  // sign-extended I and U immediates
  assign imm_i = {{(`CORE_XLEN-12){fd_inst[31]}}, fd_inst[31:20]};
  assign imm_u = {{(`CORE_XLEN-32){fd_inst[31]}}, fd_inst[31:12], 12'b0};

  always_comb begin
    supported = 1'b1;
    use_imm   = 1'b0;
    alu_op    = core_pkg::ALU_ADD;
    case (funct3)
      `CORE_F3_ADD:  alu_op = core_pkg::ALU_ADD;
      `CORE_F3_SLL:  alu_op = core_pkg::ALU_SLL;
      `CORE_F3_SLT:  alu_op = core_pkg::ALU_SLT;
      `CORE_F3_SLTU: alu_op = core_pkg::ALU_SLTU;
      `CORE_F3_XOR:  alu_op = core_pkg::ALU_XOR;
      `CORE_F3_SRL:  alu_op = core_pkg::ALU_SRL;
      `CORE_F3_OR:   alu_op = core_pkg::ALU_OR;
      default:       alu_op = core_pkg::ALU_AND;
    endcase
    case (opcode)
      `CORE_OPC_OP_IMM: begin
        use_imm = 1'b1;
        // shamt is 6 bits wide, funct6 above it must be zero (SRAI excluded)
        if (funct3 == `CORE_F3_SLL || funct3 == `CORE_F3_SRL) begin
          supported = (fd_inst[31:26] == 6'b0);
        end
      end
      `CORE_OPC_OP: begin
        if (funct3 == `CORE_F3_ADD && funct7 == `CORE_F7_SUB) begin
          alu_op = core_pkg::ALU_SUB;
        end else begin
          // SRA and the M extension fall out here
          supported = (funct7 == 7'b0);
        end
      end
      `CORE_OPC_LUI: begin
        use_imm = 1'b1;
        alu_op  = core_pkg::ALU_PASS_B;
      end
      default: supported = 1'b0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      de_valid   <= 1'b0;
      de_pc      <= '0;
      de_inst    <= '0;
      de_rs1     <= '0;
      de_rs2     <= '0;
      de_rd      <= '0;
      de_wen     <= 1'b0;
      de_use_imm <= 1'b0;
      de_imm     <= '0;
      de_alu_op  <= core_pkg::ALU_ADD;
    end else begin
      de_valid <= fd_valid;
      if (fd_valid) begin
        de_pc      <= fd_pc;
        de_inst    <= fd_inst;
        de_rs1     <= fd_inst[19:15];
        de_rs2     <= fd_inst[24:20];
        de_rd      <= rd;
        // no write to x0, none for unknown encodings
        de_wen     <= supported && (rd != '0);
        de_use_imm <= use_imm;
        de_imm     <= (opcode == `CORE_OPC_LUI) ? imm_u : imm_i;
        de_alu_op  <= alu_op;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/execute_stage.sv
// execute stage: operand forwarding, 64-bit ALU and the writeback register driving commit
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  logic                clock,
  input  logic                reset,
  // from decode
  input  logic                de_valid,
  input  core_pkg::xlen_t     de_pc,
  input  core_pkg::inst_t     de_inst,
  input  core_pkg::reg_addr_t de_rs1,
  input  core_pkg::reg_addr_t de_rs2,
  input  core_pkg::reg_addr_t de_rd,
  input  logic                de_wen,
  input  logic                de_use_imm,
  input  core_pkg::xlen_t     de_imm,
  input  core_pkg::alu_op_e   de_alu_op,
  // register file reads
  output core_pkg::reg_addr_t rs1_addr,
  output core_pkg::reg_addr_t rs2_addr,
  input  core_pkg::xlen_t     rs1_data,
  input  core_pkg::xlen_t     rs2_data,
  // writeback register, also the commit port
  output logic                commit_valid,
  output core_pkg::xlen_t     commit_pc,
  output core_pkg::inst_t     commit_inst,
  output core_pkg::reg_addr_t commit_rd,
  output logic                commit_wen,
  output core_pkg::xlen_t     commit_data
);

  logic            fwd_rs1;
  logic            fwd_rs2;
  core_pkg::xlen_t operand_a;
  core_pkg::xlen_t rs2_value;
  core_pkg::xlen_t operand_b;
  core_pkg::xlen_t result;

  assign rs1_addr = de_rs1;
  assign rs2_addr = de_rs2;

  // instruction one ahead sits in the writeback register, not yet in the file
  // commit_wen is never set for rd == x0, so x0 is never forwarded
  assign fwd_rs1 = commit_wen && (commit_rd == de_rs1);
  assign fwd_rs2 = commit_wen && (commit_rd == de_rs2);

  assign operand_a = fwd_rs1 ? commit_data : rs1_data;
  assign rs2_value = fwd_rs2 ? commit_data : rs2_data;
  assign operand_b = de_use_imm ? de_imm : rs2_value;

  always_comb begin
    case (de_alu_op)
      core_pkg::ALU_ADD:    result = operand_a + operand_b;
      core_pkg::ALU_SUB:    result = operand_a - operand_b;
      core_pkg::ALU_SLL:    result = operand_a << operand_b[5:0];
      core_pkg::ALU_SLT:    result = core_pkg::xlen_t'($signed(operand_a) < $signed(operand_b));
      core_pkg::ALU_SLTU:   result = core_pkg::xlen_t'(operand_a < operand_b);
      core_pkg::ALU_XOR:    result = operand_a ^ operand_b;
      core_pkg::ALU_SRL:    result = operand_a >> operand_b[5:0];
      core_pkg::ALU_OR:     result = operand_a | operand_b;
      core_pkg::ALU_AND:    result = operand_a & operand_b;
      core_pkg::ALU_PASS_B: result = operand_b;
      default:              result = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      commit_valid <= 1'b0;
      commit_wen   <= 1'b0;
      commit_pc    <= '0;
      commit_inst  <= '0;
      commit_rd    <= '0;
      commit_data  <= '0;
    end else begin
      commit_valid <= de_valid;
      // bubbles never write
      commit_wen   <= de_valid && de_wen;
      if (de_valid) begin
        commit_pc   <= de_pc;
        commit_inst <= de_inst;
        commit_rd   <= de_rd;
        commit_data <= result;
      end
    end
  end

  // a register write only ever accompanies a committed instruction
  commit_wen_needs_valid: assert property (
    @(posedge clock) disable iff (reset)
    commit_wen |-> commit_valid
  );

endmodule

`default_nettype wire

// File: source/fetch_stage.sv
// fetch stage: sequential pc, valid/ready fetch port and the fetch-to-decode register
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module fetch_stage (
  input  logic            clock,
  input  logic            reset,
  // fetch port
  input  logic            fetch_ready,
  input  core_pkg::inst_t fetch_inst,
  output logic            fetch_valid,
  output core_pkg::xlen_t fetch_addr,
  // to decode
  output logic            fd_valid,
  output core_pkg::xlen_t fd_pc,
  output core_pkg::inst_t fd_inst
);

  core_pkg::xlen_t pc;
  logic            transfer;

  assign fetch_addr = pc;
  assign transfer   = fetch_valid && fetch_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc          <= `CORE_RESET_PC;
      fetch_valid <= 1'b0;
      fd_valid    <= 1'b0;
      fd_pc       <= '0;
      fd_inst     <= '0;
    end else begin
      // request continuously once out of reset
      fetch_valid <= 1'b1;
      fd_valid    <= transfer;
      if (transfer) begin
        fd_pc   <= pc;
        fd_inst <= fetch_inst;
        pc      <= pc + core_pkg::xlen_t'(4);
      end
    end
  end

  // address must not move while the memory holds the request off
  fetch_addr_stable: assert property (
    @(posedge clock) disable iff (reset)
    fetch_valid && !fetch_ready |=> $stable(fetch_addr)
  );

endmodule

`default_nettype wire

// File: source/register_file.sv
// register file: 32 x 64-bit general registers, two combinational reads and one write
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module register_file (
  input  logic                clock,
  input  logic                reset,
  // reads
  input  core_pkg::reg_addr_t rs1_addr,
  input  core_pkg::reg_addr_t rs2_addr,
  output core_pkg::xlen_t     rs1_data,
  output core_pkg::xlen_t     rs2_data,
  // write
  input  logic                write_enable,
  input  core_pkg::reg_addr_t write_addr,
  input  core_pkg::xlen_t     write_data
);

  core_pkg::xlen_t regs [`CORE_REG_COUNT];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `CORE_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && write_addr != '0) begin
      regs[write_addr] <= write_data;
    end
  end

  // x0 stays at its reset value of zero
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

  // decode drops the write enable for rd == x0
  no_x0_write: assert property (
    @(posedge clock) disable iff (reset)
    write_enable |-> (write_addr != '0)
  );

endmodule

`default_nettype wire

// File: testbench/core_tb.sv
// core testbench with random instruction memory, reference model and commit checking for core_top
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module core_tb;

  localparam int          NUM_INSTS  = 600;
  localparam int          TIMEOUT_NS = NUM_INSTS * 4 * 8 + 2000;
  localparam logic [31:0] LFSR_SEED  = 32'hc87f2c19;

  logic                clock = 1'b0;
  logic                reset;
  logic                fetch_valid;
  core_pkg::xlen_t     fetch_addr;
  logic                fetch_ready;
  core_pkg::inst_t     fetch_inst;
  logic                commit_valid;
  core_pkg::xlen_t     commit_pc;
  core_pkg::inst_t     commit_inst;
  core_pkg::reg_addr_t commit_rd;
  logic                commit_wen;
  core_pkg::xlen_t     commit_data;

  logic [31:0]     lfsr_state = LFSR_SEED;
  core_pkg::xlen_t model_regs [`CORE_REG_COUNT];
  core_pkg::inst_t inst_queue [$];
  int              edge_queue [$];
  int              edge_count = 0;
  int              issued = 0;
  logic            issue_done = 1'b0;
  int              value_errors = 0;
  int              other_errors = 0;
  int              commits_checked = 0;

  core_top UUT (
    .clock        (clock),
    .reset        (reset),
    .fetch_valid  (fetch_valid),
    .fetch_addr   (fetch_addr),
    .fetch_ready  (fetch_ready),
    .fetch_inst   (fetch_inst),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_inst  (commit_inst),
    .commit_rd    (commit_rd),
    .commit_wen   (commit_wen),
    .commit_data  (commit_data)
  );

  initial begin
    forever #4 clock = ~clock;
  end

  always @(posedge clock) edge_count <= edge_count + 1;

  // galois LFSR stepped once per bit
  function automatic logic lfsr_step();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) lfsr_state = lfsr_state ^ 32'h8020_0003;
    return out;
  endfunction

  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) value = {value[30:0], lfsr_step()};
    return value;
  endfunction

  // mostly x0..x7 so that hazards come up often
  function automatic logic [4:0] pick_register();
    if (random_bits(2) == 0) return 5'(random_bits(5));
    return 5'(random_bits(3));
  endfunction

  function automatic core_pkg::inst_t make_instruction();
    logic [2:0]  kind;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [6:0]  f7;
    kind = 3'(random_bits(3));
    rd   = pick_register();
    rs1  = pick_register();
    rs2  = pick_register();
    f3   = 3'(random_bits(3));
    imm  = 12'(random_bits(12));
    case (kind)
      3'd0, 3'd1, 3'd2: begin
        // shifts need a clean funct6 except for an occasional SRAI
        if (f3 == `CORE_F3_SLL || f3 == `CORE_F3_SRL) begin
          imm[11:6] = (f3 == `CORE_F3_SRL && random_bits(2) == 0) ? 6'b010000 : 6'b0;
        end
        return {imm, rs1, f3, rd, `CORE_OPC_OP_IMM};
      end
      3'd3, 3'd4, 3'd5: begin
        f7 = (random_bits(2) == 0) ? `CORE_F7_SUB : 7'b0;
        return {f7, rs2, rs1, f3, rd, `CORE_OPC_OP};
      end
      3'd6: return {20'(random_bits(20)), rd, `CORE_OPC_LUI};
      // arbitrary word that mostly has an unsupported opcode
      default: return random_bits(32);
    endcase
  endfunction

  // RV64I rules on the model register file
  function automatic void reference_step(input core_pkg::inst_t inst, input core_pkg::xlen_t pc,
      output logic wen, output core_pkg::xlen_t data, output core_pkg::xlen_t next_pc);
    logic [6:0]      opcode;
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic [4:0]      rd;
    core_pkg::xlen_t a;
    core_pkg::xlen_t b;
    core_pkg::xlen_t imm;
    logic            ok;
    opcode = inst[6:0];
    rd     = inst[11:7];
    f3     = inst[14:12];
    f7     = inst[31:25];
    a      = model_regs[inst[19:15]];
    b      = model_regs[inst[24:20]];
    imm    = {{(`CORE_XLEN-12){inst[31]}}, inst[31:20]};
    ok     = 1'b1;
    data   = '0;
    if (opcode == `CORE_OPC_LUI) begin
      data = {{(`CORE_XLEN-32){inst[31]}}, inst[31:12], 12'h000};
    end else if (opcode == `CORE_OPC_OP_IMM || opcode == `CORE_OPC_OP) begin
      if (opcode == `CORE_OPC_OP_IMM) begin
        b  = imm;
        ok = !(f3 == `CORE_F3_SLL || f3 == `CORE_F3_SRL) || inst[31:26] == 6'b0;
      end else if (f7 == `CORE_F7_SUB && f3 == `CORE_F3_ADD) begin
        b = -b;
      end else begin
        ok = (f7 == 7'b0);
      end
      case (f3)
        `CORE_F3_ADD:  data = a + b;
        `CORE_F3_SLL:  data = a << b[5:0];
        `CORE_F3_SLT:  data = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        `CORE_F3_SLTU: data = (a < b) ? 64'd1 : 64'd0;
        `CORE_F3_XOR:  data = a ^ b;
        `CORE_F3_SRL:  data = a >> b[5:0];
        `CORE_F3_OR:   data = a | b;
        default:       data = a & b;
      endcase
    end else begin
      ok = 1'b0;
    end
    wen = ok && (rd != 5'd0);
    if (wen) model_regs[rd] = data;
    next_pc = pc + 64'd4;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] expected,
      input logic [63:0] actual);
    $display("ERR t=%0t %s expected %h got %h", $time, name, expected, actual);
    value_errors++;
  endtask

  task automatic report_failure(input string what);
    $display("error at t=%0t: %s", $time, what);
    other_errors++;
  endtask

  // reset followed by the memory side of the fetch port with random stalls
  initial begin : stimulus
    int              stall;
    logic            accepted;
    core_pkg::xlen_t expected_addr;
    reset         = 1'b1;
    fetch_ready   = 1'b0;
    fetch_inst    = '0;
    expected_addr = `CORE_RESET_PC;
    repeat (5) @(posedge clock);
    #1;
    reset       = 1'b0;
    stall       = int'(random_bits(2));
    fetch_inst  = make_instruction();
    fetch_ready = (stall == 0);
    while (issued < NUM_INSTS) begin
      @(negedge clock);
      accepted = 1'b0;
      if (fetch_valid) begin
        if (fetch_addr !== expected_addr) report_mismatch("fetch_addr", expected_addr, fetch_addr);
        if (fetch_ready) begin
          inst_queue.push_back(fetch_inst);
          edge_queue.push_back(edge_count + 1);
          expected_addr = expected_addr + 64'd4;
          issued++;
          accepted = 1'b1;
        end
      end
      @(posedge clock);
      #1;
      if (accepted) begin
        stall      = int'(random_bits(2));
        fetch_inst = make_instruction();
      end else if (stall > 0) begin
        stall--;
      end
      fetch_ready = (stall == 0) && (issued < NUM_INSTS);
    end
    issue_done = 1'b1;
  end

  task automatic check_commit(inout core_pkg::xlen_t exp_pc);
    core_pkg::inst_t inst;
    int              transfer_edge;
    logic            exp_wen;
    core_pkg::xlen_t exp_data;
    core_pkg::xlen_t next_pc;
    inst          = inst_queue.pop_front();
    transfer_edge = edge_queue.pop_front();
    reference_step(inst, exp_pc, exp_wen, exp_data, next_pc);
    if (commit_pc !== exp_pc) report_mismatch("commit_pc", exp_pc, commit_pc);
    if (commit_inst !== inst) report_mismatch("commit_inst", 64'(inst), 64'(commit_inst));
    if (commit_rd !== inst[11:7]) report_mismatch("commit_rd", 64'(inst[11:7]), 64'(commit_rd));
    if (commit_wen !== exp_wen) report_mismatch("commit_wen", 64'(exp_wen), 64'(commit_wen));
    if (exp_wen && commit_data !== exp_data) report_mismatch("commit_data", exp_data, commit_data);
    if (edge_count != transfer_edge + 2) begin
      report_mismatch("commit edge", 64'(transfer_edge + 2), 64'(edge_count));
    end
    exp_pc = next_pc;
    commits_checked++;
  endtask

  // samples at the falling edge away from the drive point
  initial begin : commit_monitor
    core_pkg::xlen_t exp_pc;
    exp_pc = `CORE_RESET_PC;
    for (int i = 0; i < `CORE_REG_COUNT; i++) model_regs[i] = '0;
    forever begin
      @(negedge clock);
      if (reset) begin
        if (fetch_valid !== 1'b0 || commit_valid !== 1'b0) begin
          report_failure("fetch_valid or commit_valid is not low during reset");
        end
      end else if (commit_valid === 1'b1) begin
        if (inst_queue.size() == 0) report_failure("commit without an outstanding instruction");
        else check_commit(exp_pc);
      end else if (commit_valid !== 1'b0 || commit_wen !== 1'b0) begin
        report_failure("commit_wen high or commit_valid unknown outside a commit");
      end
    end
  end

  initial begin : finish_run
    while (!issue_done) @(posedge clock);
    while (inst_queue.size() != 0) @(posedge clock);
    // a few idle cycles to catch stray commits
    repeat (4) @(posedge clock);
    $display("errors: %0d value mismatches, %0d other failures, %0d commits checked",
             value_errors, other_errors, commits_checked);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("timeout: %0d of %0d instructions issued, %0d commits still outstanding",
             issued, NUM_INSTS, inst_queue.size());
    $display("errors: %0d value mismatches, %0d other failures, %0d commits checked",
             value_errors, other_errors, commits_checked);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire
